/* hw/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	// parity bit selection
	typedef enum logic [1:0] {
		PAR_NONE = 2'd0,
		PAR_EVEN = 2'd1,
		PAR_ODD  = 2'd2
	} parity_mode_t;

	// one FIFO entry, host byte plus message marker
	typedef struct packed {
		logic       last;  // end of host message
		logic [7:0] data;  // sent lsb first
	} tx_byte_t;

	localparam int unsigned DEF_CLKS_PER_BIT = 16;  // clocks per serial bit
	localparam int unsigned DEF_FIFO_DEPTH   = 8;   // power of two, at least 2

endpackage

`default_nettype wire

/* hw/baud_tick_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module baud_tick_gen #(
	parameter int unsigned CLKS_PER_BIT = uart_pkg::DEF_CLKS_PER_BIT
) (
	input  wire logic clk_i,
	input  wire logic rst_i,
	output logic      tick_o
);

	localparam int unsigned CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_BIT - 1);

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	assign wrap = (cnt == CNT_MAX);  // last clock of the bit period

	// tick registered so the first one lands CLKS_PER_BIT cycles out of reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt    <= '0;
			tick_o <= 1'b0;
		end else begin
			if (wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			tick_o <= wrap;
		end
	end

endmodule

`default_nettype wire

/* hw/tx_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module tx_fifo #(
	parameter int unsigned FIFO_DEPTH = uart_pkg::DEF_FIFO_DEPTH
) (
	input  wire logic               clk_i,
	input  wire logic               rst_i,

	input  wire logic               s_valid_i,
	input  wire uart_pkg::tx_byte_t s_data_i,
	output logic                    s_ready_o,

	output logic                    m_valid_o,
	output uart_pkg::tx_byte_t      m_data_o,
	input  wire logic               m_ready_i
);

	import uart_pkg::*;

	localparam int unsigned AW = $clog2(FIFO_DEPTH);

	tx_byte_t     mem [FIFO_DEPTH];
	logic [AW:0]  wr_ptr;  // extra msb marks the wrap
	logic [AW:0]  rd_ptr;
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;
	logic         full;
	logic         empty;
	logic         push;
	logic         pop;

	assign wr_addr = wr_ptr[AW-1:0];
	assign rd_addr = rd_ptr[AW-1:0];

	// same slot, different lap means full
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_addr == rd_addr);
	assign empty = (wr_ptr == rd_ptr);

	assign s_ready_o = ~full;
	assign m_valid_o = ~empty;
	assign m_data_o  = mem[rd_addr];  // head of queue

	assign push = s_valid_i && s_ready_o;
	assign pop  = m_valid_o && m_ready_i;

	always_ff @(posedge clk_i) begin
		if (push) begin
			mem[wr_addr] <= s_data_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
		end else if (push) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_ptr <= '0;
		end else if (pop) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
	parameter uart_pkg::parity_mode_t PARITY = uart_pkg::PAR_NONE
) (
	input  wire logic               clk_i,
	input  wire logic               rst_i,
	input  wire logic               tick_i,

	input  wire logic               in_valid_i,
	input  wire uart_pkg::tx_byte_t in_data_i,
	output logic                    in_ready_o,

	output logic                    tx_o,
	output logic                    frame_done_o,
	output logic                    frame_last_o
);

	import uart_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE   = 3'd0,
		ST_START  = 3'd1,
		ST_DATA   = 3'd2,
		ST_PARITY = 3'd3,
		ST_STOP   = 3'd4
	} state_t;

	state_t     state;
	logic [2:0] bit_idx;   // data bit on the line
	logic [7:0] shift_q;   // remaining data bits
	logic       par_q;
	logic       last_q;
	logic       pop;
	logic       shift_en;
	logic       odd_flip;

	assign odd_flip = (PARITY == PAR_ODD);

	// one-cycle pop window, idle and on a tick
	assign in_ready_o = (state == ST_IDLE) && tick_i;
	assign pop        = in_ready_o && in_valid_i;

	assign shift_en = tick_i &&
		((state == ST_START) || ((state == ST_DATA) && (bit_idx != 3'd7)));

	// byte, parity and marker captured at the pop
	always_ff @(posedge clk_i) begin
		if (pop) begin
			shift_q <= in_data_i.data;
			par_q   <= (^in_data_i.data) ^ odd_flip;
			last_q  <= in_data_i.last;
		end else if (shift_en) begin
			shift_q <= {1'b0, shift_q[7:1]};
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state        <= ST_IDLE;
			bit_idx      <= '0;
			tx_o         <= 1'b1;  // line idles high
			frame_done_o <= 1'b0;
			frame_last_o <= 1'b0;
		end else begin
			frame_done_o <= 1'b0;
			if (tick_i) begin
				case (state)
					ST_IDLE: begin
						if (in_valid_i) begin
							state <= ST_START;
							tx_o  <= 1'b0;  // start bit
						end
					end

					ST_START: begin
						state   <= ST_DATA;
						bit_idx <= '0;
						tx_o    <= shift_q[0];  // bit 0
					end

					ST_DATA: begin
						if (bit_idx == 3'd7) begin
							if (PARITY == PAR_NONE) begin
								state <= ST_STOP;
								tx_o  <= 1'b1;
							end else begin
								state <= ST_PARITY;
								tx_o  <= par_q;
							end
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx_o    <= shift_q[0];
						end
					end

					ST_PARITY: begin
						state <= ST_STOP;
						tx_o  <= 1'b1;  // stop bit
					end

					ST_STOP: begin
						state        <= ST_IDLE;
						frame_done_o <= 1'b1;
						frame_last_o <= last_q;
					end

					default: begin
						state <= ST_IDLE;
						tx_o  <= 1'b1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* hw/uart_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx_top #(
	parameter int unsigned            CLKS_PER_BIT = uart_pkg::DEF_CLKS_PER_BIT,
	parameter int unsigned            FIFO_DEPTH   = uart_pkg::DEF_FIFO_DEPTH,
	parameter uart_pkg::parity_mode_t PARITY       = uart_pkg::PAR_EVEN
) (
	input  wire logic               clk_i,
	input  wire logic               rst_i,

	input  wire logic               s_valid_i,
	input  wire uart_pkg::tx_byte_t s_data_i,
	output logic                    s_ready_o,

	output logic                    tx_o,
	output logic                    frame_done_o,
	output logic                    frame_last_o
);

	import uart_pkg::*;

	logic     tick;
	logic     fifo_valid;
	tx_byte_t fifo_data;
	logic     pop_ready;

	baud_tick_gen #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) i_tick (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.tick_o (tick)
	);

	tx_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.s_valid_i (s_valid_i),
		.s_data_i  (s_data_i),
		.s_ready_o (s_ready_o),
		.m_valid_o (fifo_valid),
		.m_data_o  (fifo_data),
		.m_ready_i (pop_ready)
	);

	uart_tx #(
		.PARITY (PARITY)
	) i_tx (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.tick_i       (tick),
		.in_valid_i   (fifo_valid),
		.in_data_i    (fifo_data),
		.in_ready_o   (pop_ready),
		.tx_o         (tx_o),
		.frame_done_o (frame_done_o),
		.frame_last_o (frame_last_o)
	);

endmodule

`default_nettype wire

/* test/uart_tx_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx_sva (
	input wire logic               clk_i,
	input wire logic               rst_i,
	input wire logic [2:0]         state_i,
	input wire logic               in_valid_i,
	input wire logic               in_ready_i,
	input wire logic               tx_i,
	input wire logic               frame_done_i,
	input wire logic               s_valid_i,
	input wire logic               s_ready_i,
	input wire uart_pkg::tx_byte_t s_data_i
);

	localparam logic [2:0] ST_IDLE  = 3'd0;  // serializer idle encoding
	localparam logic [2:0] ST_START = 3'd1;

	idle_line_high: assert property (@(posedge clk_i) disable iff (rst_i)
		(state_i == ST_IDLE) |-> tx_i
	) else $error("tx_o low while the serializer is idle");

	done_single: assert property (@(posedge clk_i) disable iff (rst_i)
		frame_done_i |=> !frame_done_i
	) else $error("frame_done_o high for two cycles in a row");

	// a pop puts the start bit on the line one cycle later
	pop_starts_frame: assert property (@(posedge clk_i) disable iff (rst_i)
		(in_ready_i && in_valid_i) |=> (!tx_i && (state_i == ST_START))
	) else $error("FIFO pop not followed by a start bit");

	// host holds valid and data until accepted
	valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		(s_valid_i && !s_ready_i) |=> (s_valid_i && $stable(s_data_i))
	) else $error("s_valid_i dropped or data changed before the transfer");

endmodule

bind uart_tx_top uart_tx_sva i_sva (
	.clk_i        (clk_i),
	.rst_i        (rst_i),
	.state_i      (i_tx.state),
	.in_valid_i   (fifo_valid),
	.in_ready_i   (pop_ready),
	.tx_i         (tx_o),
	.frame_done_i (frame_done_o),
	.s_valid_i    (s_valid_i),
	.s_ready_i    (s_ready_o),
	.s_data_i     (s_data_i)
);

`default_nettype wire

/* test/tb_uart_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_uart_tx;

	import uart_pkg::*;

	localparam int           CLKS_PER_BIT = 8;
	localparam int           FIFO_DEPTH   = 4;
	localparam parity_mode_t PARITY       = PAR_EVEN;
	localparam int           CLK_PERIOD   = 4;
	localparam int           BURST_LEN    = 32;
	localparam int           MSG_LEN      = 4;
	localparam int           IDLE_CYCLES  = 5 * CLKS_PER_BIT;
	localparam int           DRAIN_BITS   = 13;  // one stray frame plus its start gap
	localparam int           NUM_DRAINS   = 4;
	localparam int           NUM_FRAMES   = 1 + BURST_LEN + (FIFO_DEPTH + 2) + MSG_LEN;
	localparam int           BIT_NS       = CLKS_PER_BIT * CLK_PERIOD;
	localparam int           WATCHDOG_NS  = NUM_FRAMES * 11 * BIT_NS + NUM_FRAMES * 2 * BIT_NS
		+ NUM_DRAINS * DRAIN_BITS * BIT_NS + 2000;

	logic        clk_i;
	logic        rst_i;
	logic        s_valid;
	tx_byte_t    s_data;
	logic        s_ready;
	logic        tx;
	logic        frame_done;
	logic        frame_last;

	tx_byte_t    sent_q[$];  // bytes accepted in write order
	logic [31:0] rng_state;
	int unsigned checks;
	int unsigned errors;
	int unsigned frames_seen;
	int unsigned done_pulses;
	int unsigned bytes_sent;

	uart_tx_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.FIFO_DEPTH   (FIFO_DEPTH),
		.PARITY       (PARITY)
	) i_dut (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.s_valid_i    (s_valid),
		.s_data_i     (s_data),
		.s_ready_o    (s_ready),
		.tx_o         (tx),
		.frame_done_o (frame_done),
		.frame_last_o (frame_last)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_i = ~clk_i;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	// expected parity bit, counted bit by bit
	function automatic logic exp_parity(input logic [7:0] data, input parity_mode_t mode);
		logic [7:0] d;
		logic       p;
		d = data;
		p = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (d[0]) begin
				p = ~p;
			end
			d = d >> 1;
		end
		if (mode == PAR_ODD) begin
			return ~p;
		end
		return p;
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output tx_byte_t b);
		rng_state = lcg_next(rng_state);
		b.data = rng_state[23:16];
		b.last = rng_state[27];
	endtask

	task automatic check_byte(input string name, input tx_byte_t got, input tx_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int unsigned got, input int unsigned exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// called on a falling edge and returns one falling edge after the transfer
	task automatic send_byte(input tx_byte_t b, inout bit stalled);
		s_valid = 1'b1;
		s_data  = b;
		while (!s_ready) begin
			stalled = 1'b1;
			@(negedge clk_i);
		end
		sent_q.push_back(b);
		bytes_sent++;
		@(negedge clk_i);
	endtask

	// serial line decoder and comparison against the sent queue
	task automatic decode_frames();
		tx_byte_t got;
		tx_byte_t exp;
		logic     start_bit;
		logic     par_bit;
		logic     stop_bit;
		bit       seen_done;
		forever begin
			@(negedge tx);
			repeat (CLKS_PER_BIT / 2) @(negedge clk_i);  // middle of start bit
			start_bit = tx;
			got = '0;
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk_i);
				got.data = {tx, got.data[7:1]};  // lsb arrives first
			end
			repeat (CLKS_PER_BIT) @(negedge clk_i);
			par_bit = tx;
			repeat (CLKS_PER_BIT) @(negedge clk_i);
			stop_bit = tx;
			seen_done = 1'b0;
			for (int i = 0; i < CLKS_PER_BIT && !seen_done; i++) begin
				@(negedge clk_i);
				if (frame_done) begin
					seen_done = 1'b1;
					got.last  = frame_last;
				end
			end
			if (!seen_done) begin
				errors++;
				$display("frame_done_o did not pulse after the stop bit of frame %0d", frames_seen);
			end
			if (sent_q.size() == 0) begin
				errors++;
				$display("a frame came out on tx_o with no written byte left to match it");
			end else begin
				exp = sent_q.pop_front();
				check_bit("start bit", start_bit, 1'b0);
				check_byte("tx_o frame", got, exp);
				check_bit("parity bit", par_bit, exp_parity(exp.data, PARITY));
				check_bit("stop bit", stop_bit, 1'b1);
			end
			frames_seen++;
		end
	endtask

	task automatic count_done_pulses();
		forever begin
			@(negedge clk_i);
			if (frame_done) begin
				done_pulses++;
			end
		end
	endtask

	task automatic wait_drain();
		while (frames_seen < bytes_sent) begin
			@(negedge clk_i);
		end
		repeat (DRAIN_BITS * CLKS_PER_BIT) @(negedge clk_i);  // room for a stray extra frame
	endtask

	task automatic report_test(input string name, input int unsigned err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	initial begin
		tx_byte_t    b;
		bit          stalled;
		int unsigned err_mark;
		rst_i       = 1'b1;
		s_valid     = 1'b0;
		s_data      = '0;
		rng_state   = 32'h1c6e;
		checks      = 0;
		errors      = 0;
		frames_seen = 0;
		done_pulses = 0;
		bytes_sent  = 0;
		stalled     = 1'b0;
		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		fork
			decode_frames();
			count_done_pulses();
		join_none

		err_mark = errors;
		repeat (IDLE_CYCLES) begin
			@(negedge clk_i);
			check_bit("tx_o", tx, 1'b1);
			check_bit("s_ready_o", s_ready, 1'b1);
		end
		report_test("idle after reset", err_mark);

		err_mark = errors;
		b.data = 8'h3c;
		b.last = 1'b1;
		send_byte(b, stalled);
		s_valid = 1'b0;
		wait_drain();
		report_test("single byte", err_mark);

		err_mark = errors;
		for (int i = 0; i < BURST_LEN; i++) begin
			next_random(b);
			send_byte(b, stalled);
		end
		s_valid = 1'b0;
		wait_drain();
		report_test("random burst", err_mark);

		err_mark = errors;
		stalled  = 1'b0;
		for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
			next_random(b);
			send_byte(b, stalled);
		end
		s_valid = 1'b0;
		checks++;
		if (!stalled) begin
			errors++;
			$display("s_ready_o never went low while the FIFO was overfilled");
		end
		wait_drain();
		check_count("frames decoded", frames_seen, bytes_sent);
		report_test("back-pressure", err_mark);

		err_mark = errors;
		for (int i = 0; i < MSG_LEN; i++) begin
			next_random(b);
			b.last = (i == MSG_LEN - 1);  // marks the end of the message
			send_byte(b, stalled);
		end
		s_valid = 1'b0;
		wait_drain();
		check_count("frame_done_o pulses", done_pulses, bytes_sent);
		check_count("frames decoded", frames_seen, bytes_sent);
		report_test("frame done and last flag", err_mark);

		$display("checks %0d, errors %0d, frames %0d", checks, errors, frames_seen);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/tx_fifo.sv
hw/uart_tx.sv
hw/uart_tx_top.sv
test/uart_tx_sva.sv
test/tb_uart_tx.sv

/* run.sh */
#!/bin/sh
# build the UART transmit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/10ps \
	--top-module tb_uart_tx \
	-f all.f \
	-o sim_uart_tx

if ! ./obj_dir/sim_uart_tx > sim.log 2>&1; then
	cat sim.log
	echo "simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -qF '** FAIL **' sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
